// ==== common/axi_wr_pkg.sv ====
package axi_wr_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    // Byte address on AW
    localparam int ADDR_W = 32;

    // Full-width data bus
    localparam int DATA_W = 32;

    // Byte lanes per word
    localparam int STRB_W = DATA_W / 8;

    // Byte offset bits within a word
    localparam int STRB_LOG2 = 2;

    // Transfer byte count from the start strobe
    localparam int COUNT_W = 16;

    // Word address towards the local SRAM
    localparam int SRAM_ADDR_W = 32;

    // ------------------------------
    // Burst constants
    // ------------------------------

    // INCR burst limit
    localparam int MAX_BEATS = 256;

    // Bytes covered by one full burst
    localparam int BURST_BYTES = MAX_BEATS * STRB_W;

    // AWLEN field
    localparam int LEN_W = 8;

    // BRESP field whose upper bit marks SLVERR or DECERR
    localparam int RESP_W = 2;

endpackage

// ==== axi_wr/burst_planner.sv ====
`timescale 1ns/10ps

module burst_planner (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             w_start_i,
    input  logic [axi_wr_pkg::ADDR_W-1:0]    w_addr_i,
    input  logic [axi_wr_pkg::COUNT_W-1:0]   w_byte_num_i,
    input  logic                             busy_i,
    input  logic                             awready_i,
    input  logic                             resp_done_i,
    output logic [axi_wr_pkg::ADDR_W-1:0]    awaddr_o,
    output logic [axi_wr_pkg::LEN_W-1:0]     awlen_o,
    output logic                             awvalid_o,
    output logic                             burst_start_o,
    output logic [axi_wr_pkg::LEN_W-1:0]     burst_len_o,
    output logic [axi_wr_pkg::STRB_W-1:0]    first_strb_o,
    output logic [axi_wr_pkg::STRB_W-1:0]    last_strb_o,
    output logic                             final_burst_o
);

    logic [axi_wr_pkg::STRB_LOG2-1:0] addr_off;
    logic [axi_wr_pkg::COUNT_W:0]     eff_cnt;
    logic [axi_wr_pkg::COUNT_W:0]     remain_q;
    logic [axi_wr_pkg::ADDR_W-1:0]    addr_q;
    logic [axi_wr_pkg::LEN_W-1:0]     awlen_q;
    logic [axi_wr_pkg::STRB_W-1:0]    start_mask_q;
    logic [axi_wr_pkg::STRB_W-1:0]    end_mask_q;
    logic                             awvalid_q;
    logic                             busy_q;
    logic                             burst_go;
    logic                             first_q;
    logic                             final_q;
    logic                             aw_fire;
    logic                             last_now;

    assign addr_off = w_addr_i[axi_wr_pkg::STRB_LOG2-1:0];

    // Count includes the leading bytes skipped by alignment
    assign eff_cnt = {1'b0, w_byte_num_i}
                   + {{(axi_wr_pkg::COUNT_W + 1 - axi_wr_pkg::STRB_LOG2){1'b0}}, addr_off};

    assign aw_fire  = awvalid_q & awready_i;
    assign last_now = remain_q <= (axi_wr_pkg::COUNT_W + 1)'(axi_wr_pkg::BURST_BYTES);

    // ------------------------------
    // Transfer setup
    // ------------------------------

    always_ff @(posedge clk) begin
        if (w_start_i) begin
            start_mask_q <= {axi_wr_pkg::STRB_W{1'b1}} << addr_off;
            if (eff_cnt[axi_wr_pkg::STRB_LOG2-1:0] == '0) begin
                end_mask_q <= {axi_wr_pkg::STRB_W{1'b1}};
            end else begin
                end_mask_q <= ~({axi_wr_pkg::STRB_W{1'b1}} << eff_cnt[axi_wr_pkg::STRB_LOG2-1:0]);
            end
        end
    end

    // Aligned base, then one full burst further on per AW
    always_ff @(posedge clk) begin
        if (w_start_i) begin
            addr_q <= {w_addr_i[axi_wr_pkg::ADDR_W-1:axi_wr_pkg::STRB_LOG2],
                       {axi_wr_pkg::STRB_LOG2{1'b0}}};
        end else if (aw_fire) begin
            addr_q <= addr_q + axi_wr_pkg::ADDR_W'(axi_wr_pkg::BURST_BYTES);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain_q <= '0;
            first_q  <= 1'b0;
            final_q  <= 1'b0;
        end else if (w_start_i) begin
            remain_q <= eff_cnt;
            first_q  <= 1'b1;
            final_q  <= 1'b0;
        end else if (aw_fire) begin
            if (last_now) begin
                remain_q <= '0;
            end else begin
                remain_q <= remain_q - (axi_wr_pkg::COUNT_W + 1)'(axi_wr_pkg::BURST_BYTES);
            end
            first_q <= 1'b0;
            final_q <= last_now;
        end
    end

    // ------------------------------
    // AW issue
    // ------------------------------

    // First burst on the rise of busy, later ones after each response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            burst_go <= 1'b0;
        end else begin
            busy_q   <= busy_i;
            burst_go <= (busy_i & ~busy_q) | (resp_done_i & ~final_q);
        end
    end

    always_ff @(posedge clk) begin
        if (burst_go) begin
            if (remain_q >= (axi_wr_pkg::COUNT_W + 1)'(axi_wr_pkg::BURST_BYTES)) begin
                awlen_q <= axi_wr_pkg::LEN_W'(axi_wr_pkg::MAX_BEATS - 1);
            end else begin
                // Partial word at the end still takes a beat
                awlen_q <= axi_wr_pkg::LEN_W'((remain_q - 1'b1) >> axi_wr_pkg::STRB_LOG2);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvalid_q <= 1'b0;
        end else if (burst_go) begin
            awvalid_q <= 1'b1;
        end else if (aw_fire) begin
            awvalid_q <= 1'b0;
        end
    end

    assign awaddr_o      = addr_q;
    assign awlen_o       = awlen_q;
    assign awvalid_o     = awvalid_q;
    assign burst_start_o = aw_fire;
    assign burst_len_o   = awlen_q;
    assign first_strb_o  = first_q ? start_mask_q : {axi_wr_pkg::STRB_W{1'b1}};
    assign last_strb_o   = last_now ? end_mask_q : {axi_wr_pkg::STRB_W{1'b1}};
    assign final_burst_o = final_q;

    // AW payload holds while the slave stalls
    aw_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_q && !awready_i |=> awvalid_q && $stable(awaddr_o) && $stable(awlen_o));

    // Last beat lies inside the remaining bytes and a short burst covers all of them
    aw_len_a : assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_q |-> (int'(awlen_o) * axi_wr_pkg::STRB_W < int'(remain_q)
                       && (int'(awlen_o) == axi_wr_pkg::MAX_BEATS - 1
                           || int'(remain_q) <= (int'(awlen_o) + 1) * axi_wr_pkg::STRB_W)));

endmodule

// ==== axi_wr/wbeat_gen.sv ====
`timescale 1ns/10ps

module wbeat_gen (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                w_start_i,
    input  logic                                burst_start_i,
    input  logic [axi_wr_pkg::LEN_W-1:0]        burst_len_i,
    input  logic [axi_wr_pkg::STRB_W-1:0]       first_strb_i,
    input  logic [axi_wr_pkg::STRB_W-1:0]       last_strb_i,
    input  logic                                wready_i,
    input  logic [axi_wr_pkg::DATA_W-1:0]       w_data_i,
    output logic [axi_wr_pkg::DATA_W-1:0]       wdata_o,
    output logic [axi_wr_pkg::STRB_W-1:0]       wstrb_o,
    output logic                                wlast_o,
    output logic                                wvalid_o,
    output logic                                sram_req_o,
    output logic [axi_wr_pkg::SRAM_ADDR_W-1:0]  sram_addr_o,
    output logic                                data_done_o
);

    logic [axi_wr_pkg::LEN_W-1:0]       len_q;
    logic [axi_wr_pkg::LEN_W-1:0]       beat_q;
    logic [axi_wr_pkg::STRB_W-1:0]      first_mask_q;
    logic [axi_wr_pkg::STRB_W-1:0]      last_mask_q;
    logic [axi_wr_pkg::STRB_W-1:0]      head_mask;
    logic [axi_wr_pkg::STRB_W-1:0]      tail_mask;
    logic [axi_wr_pkg::SRAM_ADDR_W-1:0] word_addr_q;
    logic                               wvalid_q;
    logic                               wnext;
    logic                               last_beat;

    assign wnext     = wvalid_q & wready_i;
    assign last_beat = beat_q == len_q;

    // ------------------------------
    // Burst context
    // ------------------------------

    // Captured on the AW transfer, held for the whole burst
    always_ff @(posedge clk) begin
        if (burst_start_i) begin
            len_q        <= burst_len_i;
            first_mask_q <= first_strb_i;
            last_mask_q  <= last_strb_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (burst_start_i) begin
            beat_q <= '0;
        end else if (wnext && !last_beat) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid_q <= 1'b0;
        end else if (burst_start_i) begin
            wvalid_q <= 1'b1;
        end else if (wnext && last_beat) begin
            wvalid_q <= 1'b0;
        end
    end

    // ------------------------------
    // Strobes
    // ------------------------------

    // A one-beat burst gets both masks
    assign head_mask = (beat_q == '0) ? first_mask_q : {axi_wr_pkg::STRB_W{1'b1}};
    assign tail_mask = last_beat ? last_mask_q : {axi_wr_pkg::STRB_W{1'b1}};

    assign wstrb_o     = head_mask & tail_mask;
    assign wlast_o     = last_beat;
    assign wvalid_o    = wvalid_q;
    assign wdata_o     = w_data_i;
    assign data_done_o = wnext & last_beat;

    // ------------------------------
    // SRAM fetch
    // ------------------------------

    // Word for beat 0 comes with the AW, the rest follow accepted beats
    assign sram_req_o = burst_start_i | (wnext & ~last_beat);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_addr_q <= '0;
        end else if (w_start_i) begin
            word_addr_q <= '0;
        end else if (sram_req_o) begin
            word_addr_q <= word_addr_q + 1'b1;
        end
    end

    assign sram_addr_o = word_addr_q;

    // Beat and its data stay put under WREADY back-pressure
    w_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_q && !wready_i |=> wvalid_q && $stable(wstrb_o) && $stable(wlast_o)
                                  && $stable(wdata_o));

endmodule

// ==== axi_wr/wresp_track.sv ====
`timescale 1ns/10ps

module wresp_track (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             w_start_i,
    input  logic                             data_done_i,
    input  logic                             final_burst_i,
    input  logic                             bvalid_i,
    input  logic [axi_wr_pkg::RESP_W-1:0]    bresp_i,
    output logic                             bready_o,
    output logic                             resp_done_o,
    output logic                             busy_o,
    output logic                             error_o
);

    logic bready_q;
    logic b_fire;

    assign b_fire = bready_q & bvalid_i;

    // Open for the response once the burst's last beat is out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bready_q <= 1'b0;
        end else if (data_done_i) begin
            bready_q <= 1'b1;
        end else if (b_fire) begin
            bready_q <= 1'b0;
        end
    end

    // ------------------------------
    // Status
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
        end else if (w_start_i) begin
            busy_o <= 1'b1;
        end else if (b_fire && final_burst_i) begin
            busy_o <= 1'b0;
        end
    end

    // SLVERR and DECERR both carry the upper BRESP bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_o <= 1'b0;
        end else if (w_start_i) begin
            error_o <= 1'b0;
        end else if (b_fire && bresp_i[axi_wr_pkg::RESP_W-1]) begin
            error_o <= 1'b1;
        end
    end

    assign bready_o    = bready_q;
    assign resp_done_o = b_fire;

endmodule

// ==== axi_wr/axi_wr_ctrl.sv ====
`timescale 1ns/10ps

module axi_wr_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                w_start_i,
    input  logic [axi_wr_pkg::ADDR_W-1:0]       w_addr_i,
    input  logic [axi_wr_pkg::COUNT_W-1:0]      w_byte_num_i,
    input  logic [axi_wr_pkg::DATA_W-1:0]       w_data_i,
    output logic                                busy_o,
    output logic                                error_o,
    output logic [axi_wr_pkg::SRAM_ADDR_W-1:0]  sram_addr_o,
    output logic                                sram_req_o,
    // AW channel
    output logic [axi_wr_pkg::ADDR_W-1:0]       m_awaddr_o,
    output logic [axi_wr_pkg::LEN_W-1:0]        m_awlen_o,
    output logic                                m_awvalid_o,
    input  logic                                m_awready_i,
    // W channel
    output logic [axi_wr_pkg::DATA_W-1:0]       m_wdata_o,
    output logic [axi_wr_pkg::STRB_W-1:0]       m_wstrb_o,
    output logic                                m_wlast_o,
    output logic                                m_wvalid_o,
    input  logic                                m_wready_i,
    // B channel
    input  logic [axi_wr_pkg::RESP_W-1:0]       m_bresp_i,
    input  logic                                m_bvalid_i,
    output logic                                m_bready_o
);

    logic                            burst_start;
    logic [axi_wr_pkg::LEN_W-1:0]    burst_len;
    logic [axi_wr_pkg::STRB_W-1:0]   first_strb;
    logic [axi_wr_pkg::STRB_W-1:0]   last_strb;
    logic                            final_burst;
    logic                            data_done;
    logic                            resp_done;

    burst_planner burst_planner_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_start_i     (w_start_i),
        .w_addr_i      (w_addr_i),
        .w_byte_num_i  (w_byte_num_i),
        .busy_i        (busy_o),
        .awready_i     (m_awready_i),
        .resp_done_i   (resp_done),
        .awaddr_o      (m_awaddr_o),
        .awlen_o       (m_awlen_o),
        .awvalid_o     (m_awvalid_o),
        .burst_start_o (burst_start),
        .burst_len_o   (burst_len),
        .first_strb_o  (first_strb),
        .last_strb_o   (last_strb),
        .final_burst_o (final_burst)
    );

    wbeat_gen wbeat_gen_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_start_i     (w_start_i),
        .burst_start_i (burst_start),
        .burst_len_i   (burst_len),
        .first_strb_i  (first_strb),
        .last_strb_i   (last_strb),
        .wready_i      (m_wready_i),
        .w_data_i      (w_data_i),
        .wdata_o       (m_wdata_o),
        .wstrb_o       (m_wstrb_o),
        .wlast_o       (m_wlast_o),
        .wvalid_o      (m_wvalid_o),
        .sram_req_o    (sram_req_o),
        .sram_addr_o   (sram_addr_o),
        .data_done_o   (data_done)
    );

    wresp_track wresp_track_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_start_i     (w_start_i),
        .data_done_i   (data_done),
        .final_burst_i (final_burst),
        .bvalid_i      (m_bvalid_i),
        .bresp_i       (m_bresp_i),
        .bready_o      (m_bready_o),
        .resp_done_o   (resp_done),
        .busy_o        (busy_o),
        .error_o       (error_o)
    );

endmodule

// ==== testbench/axi_slave_model.sv ====
`timescale 1ns/10ps

module axi_slave_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [31:0]                         rand_i,
    input  logic                                stall_i,
    input  logic                                err_i,
    input  logic [31:0]                         salt_i,
    input  logic [axi_wr_pkg::ADDR_W-1:0]       awaddr_i,
    input  logic [axi_wr_pkg::LEN_W-1:0]        awlen_i,
    input  logic                                awvalid_i,
    output logic                                awready_o,
    input  logic [axi_wr_pkg::DATA_W-1:0]       wdata_i,
    input  logic [axi_wr_pkg::STRB_W-1:0]       wstrb_i,
    input  logic                                wlast_i,
    input  logic                                wvalid_i,
    output logic                                wready_o,
    output logic [axi_wr_pkg::RESP_W-1:0]       bresp_o,
    output logic                                bvalid_o,
    input  logic                                bready_i,
    input  logic                                sram_req_i,
    input  logic [axi_wr_pkg::SRAM_ADDR_W-1:0]  sram_addr_i,
    output logic [axi_wr_pkg::DATA_W-1:0]       sram_data_o
);

    // Transfer logs that the testbench reads after each transfer
    logic [axi_wr_pkg::ADDR_W-1:0]  aw_addr_log [0:63];
    logic [axi_wr_pkg::LEN_W-1:0]   aw_len_log [0:63];
    logic [axi_wr_pkg::DATA_W-1:0]  w_data_log [0:16383];
    logic [axi_wr_pkg::STRB_W-1:0]  w_strb_log [0:16383];
    logic                           w_last_log [0:16383];
    logic [axi_wr_pkg::RESP_W-1:0]  b_resp_log [0:63];
    int                             aw_cnt;
    int                             w_cnt;
    int                             b_cnt;
    int                             pending;
    time                            b_time;

    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic        req;
    logic        st;
    logic        er;
    logic [31:0] req_addr;
    logic [31:0] r;
    logic [31:0] sl;

    // SRAM fill that depends on every bit of the word address
    function automatic logic [31:0] sram_word(input logic [31:0] a, input logic [31:0] s);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ s;
    endfunction

    initial begin
        awready_o   = 1'b0;
        wready_o    = 1'b0;
        bvalid_o    = 1'b0;
        bresp_o     = '0;
        sram_data_o = '0;
        aw_cnt      = 0;
        w_cnt       = 0;
        b_cnt       = 0;
        pending     = 0;
        b_time      = 0;
    end

    // Sample on the edge and answer 1 ns later
    always @(posedge clk) begin
        aw_fire  = awvalid_i & awready_o;
        w_fire   = wvalid_i & wready_o;
        b_fire   = bvalid_o & bready_i;
        req      = sram_req_i;
        req_addr = sram_addr_i;
        r        = rand_i;
        st       = stall_i;
        er       = err_i;
        sl       = salt_i;
        if (aw_fire) begin
            aw_addr_log[aw_cnt] = awaddr_i;
            aw_len_log[aw_cnt]  = awlen_i;
            aw_cnt++;
        end
        if (w_fire) begin
            w_data_log[w_cnt] = wdata_i;
            w_strb_log[w_cnt] = wstrb_i;
            w_last_log[w_cnt] = wlast_i;
            w_cnt++;
            if (wlast_i) begin
                pending++;
            end
        end
        if (b_fire) begin
            b_resp_log[b_cnt] = bresp_o;
            b_cnt++;
            b_time = $time;
            pending--;
        end
        #1;
        if (!rst_n) begin
            awready_o = 1'b0;
            wready_o  = 1'b0;
            bvalid_o  = 1'b0;
            pending   = 0;
        end else begin
            if (req) begin
                sram_data_o = sram_word(req_addr, sl);
            end
            if (b_fire) begin
                bvalid_o = 1'b0;
            end
            if (!bvalid_o && pending > 0 && (!st || r[29])) begin
                bvalid_o = 1'b1;
                // Error mode answers SLVERR or DECERR
                bresp_o  = er ? {1'b1, r[27]} : 2'b00;
            end
            awready_o = !st || r[31];
            wready_o  = !st || r[30];
        end
    end

endmodule

// ==== testbench/tb_axi_wr.sv ====
`timescale 1ns/10ps

module tb_axi_wr;

    localparam int NUM_TESTS   = 11;
    // Most words in one transfer, and cycles allowed per word under back-pressure
    localparam int MAX_WORDS   = 3000 / axi_wr_pkg::STRB_W + 2;
    localparam int READY_DELAY = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * (MAX_WORDS * READY_DELAY + 100);

    logic                                clk;
    logic                                rst_n;
    logic                                w_start;
    logic [axi_wr_pkg::ADDR_W-1:0]       w_addr;
    logic [axi_wr_pkg::COUNT_W-1:0]      w_byte_num;
    logic [axi_wr_pkg::DATA_W-1:0]       w_data;
    logic                                busy;
    logic                                error;
    logic [axi_wr_pkg::SRAM_ADDR_W-1:0]  sram_addr;
    logic                                sram_req;
    logic [axi_wr_pkg::ADDR_W-1:0]       awaddr;
    logic [axi_wr_pkg::LEN_W-1:0]        awlen;
    logic                                awvalid;
    logic                                awready;
    logic [axi_wr_pkg::DATA_W-1:0]       wdata;
    logic [axi_wr_pkg::STRB_W-1:0]       wstrb;
    logic                                wlast;
    logic                                wvalid;
    logic                                wready;
    logic [axi_wr_pkg::RESP_W-1:0]       bresp;
    logic                                bvalid;
    logic                                bready;
    logic [31:0]                         slave_rand;
    logic [31:0]                         ready_state;
    logic [31:0]                         param_state;
    logic [31:0]                         salt;
    logic                                stall;
    logic                                err_mode;
    int                                  errors;
    int                                  test_errors;
    int                                  cur_test;
    int                                  cycles;
    int                                  req_cnt;

    axi_wr_ctrl axi_wr_ctrl_i (
        .clk(clk), .rst_n(rst_n), .w_start_i(w_start), .w_addr_i(w_addr),
        .w_byte_num_i(w_byte_num), .w_data_i(w_data), .busy_o(busy), .error_o(error),
        .sram_addr_o(sram_addr), .sram_req_o(sram_req),
        .m_awaddr_o(awaddr), .m_awlen_o(awlen), .m_awvalid_o(awvalid), .m_awready_i(awready),
        .m_wdata_o(wdata), .m_wstrb_o(wstrb), .m_wlast_o(wlast), .m_wvalid_o(wvalid),
        .m_wready_i(wready), .m_bresp_i(bresp), .m_bvalid_i(bvalid), .m_bready_o(bready)
    );

    axi_slave_model slave_i (
        .clk(clk), .rst_n(rst_n), .rand_i(slave_rand), .stall_i(stall), .err_i(err_mode),
        .salt_i(salt), .awaddr_i(awaddr), .awlen_i(awlen), .awvalid_i(awvalid),
        .awready_o(awready), .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast),
        .wvalid_i(wvalid), .wready_o(wready), .bresp_o(bresp), .bvalid_o(bvalid),
        .bready_i(bready), .sram_req_i(sram_req), .sram_addr_i(sram_addr), .sram_data_o(w_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected SRAM contents for word a
    function automatic logic [31:0] expected_word(input logic [31:0] a, input logic [31:0] s);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ s;
    endfunction

    task automatic draw(output logic [31:0] v);
        param_state = lcg_step(param_state);
        v = param_state;
    endtask

    task automatic expect_value(input string sig, input int idx, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL test %0d %s[%0d]: got %h expected %h", cur_test, sig, idx, got, exp);
            test_errors++;
        end
    endtask

    // Ready pattern for the slave with one new word per cycle
    always @(posedge clk) begin
        #1;
        ready_state = lcg_step(ready_state);
        slave_rand  = ready_state;
    end

    // SRAM requests walk the words of the transfer from zero
    always @(posedge clk) begin
        if (w_start) begin
            req_cnt = 0;
        end else if (sram_req) begin
            expect_value("sram_addr_o", req_cnt, sram_addr, req_cnt);
            req_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: transfers did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------
    // One transfer and its checks
    // ------------------------------

    task automatic run_test(input int idx, input string name, input logic [31:0] addr,
                            input int cnt, input logic stall_en, input logic err_en);
        int         aw0;
        int         w0;
        int         b0;
        int         n;
        int         eff;
        int         words;
        int         bursts;
        int         rem;
        logic [3:0] strb_exp;
        logic       err_exp;
        time        fall_time;
        cur_test    = idx;
        test_errors = 0;
        aw0 = slave_i.aw_cnt;
        w0  = slave_i.w_cnt;
        b0  = slave_i.b_cnt;
        stall      = stall_en;
        err_mode   = err_en;
        salt       = addr ^ (cnt * 32'h01000193);
        w_addr     = addr;
        w_byte_num = cnt[15:0];
        w_start    = 1'b1;
        @(posedge clk);
        #1;
        w_start = 1'b0;
        n = 1;
        expect_value("busy_o", 0, busy, 1);
        while (!awvalid) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n != 3) begin
            $display("test %0d: AWVALID rose %0d cycles after the start strobe, not 3", idx, n);
            test_errors++;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
        fall_time = $time;
        if (fall_time != slave_i.b_time + 1) begin
            $display("test %0d: busy_o did not fall in the cycle after the final B transfer", idx);
            test_errors++;
        end
        eff    = cnt + addr[1:0];
        words  = (eff + axi_wr_pkg::STRB_W - 1) / axi_wr_pkg::STRB_W;
        bursts = (eff + axi_wr_pkg::BURST_BYTES - 1) / axi_wr_pkg::BURST_BYTES;
        if (req_cnt != words) begin
            $display("test %0d: %0d SRAM requests issued for %0d words", idx, req_cnt, words);
            test_errors++;
        end
        if (slave_i.aw_cnt - aw0 != bursts || slave_i.b_cnt - b0 != bursts) begin
            $display("test %0d: %0d AW and %0d B transfers seen for %0d bursts", idx,
                     slave_i.aw_cnt - aw0, slave_i.b_cnt - b0, bursts);
            test_errors++;
        end else begin
            for (int b = 0; b < bursts; b++) begin
                rem = eff - b * axi_wr_pkg::BURST_BYTES;
                expect_value("m_awaddr_o", b, slave_i.aw_addr_log[aw0 + b],
                             {addr[31:2], 2'b00} + b * axi_wr_pkg::BURST_BYTES);
                expect_value("m_awlen_o", b, slave_i.aw_len_log[aw0 + b],
                             rem >= axi_wr_pkg::BURST_BYTES ? axi_wr_pkg::MAX_BEATS - 1
                                                            : (rem + 3) / 4 - 1);
            end
        end
        if (slave_i.w_cnt - w0 != words) begin
            $display("test %0d: %0d W beats seen for %0d words", idx, slave_i.w_cnt - w0, words);
            test_errors++;
        end else begin
            for (int k = 0; k < words; k++) begin
                // Lane j of word k holds byte 4k+j of the aligned span
                for (int j = 0; j < axi_wr_pkg::STRB_W; j++) begin
                    strb_exp[j] = (k * axi_wr_pkg::STRB_W + j >= int'(addr[1:0]))
                                  && (k * axi_wr_pkg::STRB_W + j < eff);
                end
                expect_value("m_wdata_o", k, slave_i.w_data_log[w0 + k], expected_word(k, salt));
                expect_value("m_wstrb_o", k, slave_i.w_strb_log[w0 + k], strb_exp);
                expect_value("m_wlast_o", k, slave_i.w_last_log[w0 + k],
                             (k % axi_wr_pkg::MAX_BEATS == axi_wr_pkg::MAX_BEATS - 1)
                             || (k == words - 1));
            end
        end
        err_exp = 1'b0;
        for (int b = b0; b < slave_i.b_cnt; b++) begin
            err_exp = err_exp | slave_i.b_resp_log[b][1];
        end
        expect_value("error_o", 0, error, err_exp);
        $display("test %0d %s addr %h bytes %0d bursts %0d: %s", idx, name, addr, cnt, bursts,
                 test_errors == 0 ? "ok" : "mismatch");
        errors += test_errors;
    endtask

    initial begin
        logic [31:0] r_addr;
        logic [31:0] r_cnt;
        int          cnt;
        clk         = 1'b0;
        rst_n       = 1'b0;
        w_start     = 1'b0;
        w_addr      = '0;
        w_byte_num  = '0;
        stall       = 1'b0;
        err_mode    = 1'b0;
        salt        = '0;
        slave_rand  = '0;
        param_state = 32'hb30c;
        ready_state = ~32'hb30c;
        errors      = 0;
        test_errors = 0;
        cur_test    = 0;
        cycles      = 0;
        req_cnt     = 0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        expect_value("m_awvalid_o", 0, awvalid, 0);
        expect_value("m_wvalid_o", 0, wvalid, 0);
        expect_value("m_bready_o", 0, bready, 0);
        expect_value("sram_req_o", 0, sram_req, 0);
        expect_value("busy_o", 0, busy, 0);
        expect_value("error_o", 0, error, 0);
        $display("reset: outputs %s", test_errors == 0 ? "idle" : "not idle");
        errors += test_errors;
        for (int i = 0; i < NUM_TESTS; i++) begin
            draw(r_addr);
            draw(r_cnt);
            r_addr = r_addr & 32'h000f_ffff;
            cnt    = 1 + r_cnt[31:16] % 3000;
            if (i < 2) begin
                run_test(i, "aligned", r_addr & ~32'h3, 4 * (1 + r_cnt[31:16] % 750), 0, 0);
            end else if (i < 4) begin
                run_test(i, "unaligned", r_addr, cnt, 0, 0);
            end else if (i == 4) begin
                // Offset 1 and two bytes, so both masks land on one beat
                run_test(i, "one-beat", (r_addr & ~32'h3) | 32'h1, 2, 0, 0);
            end else if (i < 9) begin
                run_test(i, "stall", r_addr, cnt, 1, 0);
            end else if (i == 9) begin
                run_test(i, "error", r_addr, cnt, 1, 1);
            end else begin
                run_test(i, "recover", r_addr, cnt, 1, 0);
            end
        end
        $display("%0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/axi_wr_pkg.sv
axi_wr/burst_planner.sv
axi_wr/wbeat_gen.sv
axi_wr/wresp_track.sv
axi_wr/axi_wr_ctrl.sv
testbench/axi_slave_model.sv
testbench/tb_axi_wr.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_axi_wr \
		--Mdir obj_dir -o tb_axi_wr
	./obj_dir/tb_axi_wr | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
